//--- vlog.f
source/alu_isa_pkg.sv
source/alu_data_pkg.sv
source/alu_logic_unit.sv
source/shifter.sv
source/multiplier.sv
source/divider.sv
source/alu.sv
verif/alu_tb.sv

//--- Bender.yml
package:
  name: alu

sources:
  - source/alu_isa_pkg.sv
  - source/alu_data_pkg.sv
  - source/alu_logic_unit.sv
  - source/shifter.sv
  - source/multiplier.sv
  - source/divider.sv
  - source/alu.sv
  - target: test
    files:
      - verif/alu_tb.sv

//--- verif/alu_tb.sv
`timescale 1ns/1ps

module alu_tb;
	import alu_isa_pkg::*;
	import alu_data_pkg::*;

	// Test counts set the timeout budget
	localparam int LOGIC_TESTS = 6 * 13;
	localparam int SHIFT_TESTS = 6 * 32;
	localparam int NUM_TESTS   = 1 + LOGIC_TESTS + SHIFT_TESTS + 10 + 10 + 4 + 1;
	localparam int CYCLE_LIMIT = NUM_TESTS * 40 + 100;
	localparam int ITER_LATENCY = 34;

	logic        clock = 1'b0;
	logic        rst_n;
	logic        start;
	alu_req_t    req;
	logic        busy;
	logic        done;
	alu_result_t result;

	int seed = 18521;
	int error_count = 0;
	int pass_count = 0;
	int fail_count = 0;
	int cycle_count = 0;

	alu_op_e     logic_ops [6] = '{OP_NOT, OP_AND, OP_OR, OP_ADD, OP_SUB, OP_NEG};
	alu_op_e     shift_ops [6] = '{OP_SHL, OP_SHR, OP_ROL, OP_ROR, OP_SHLA, OP_SHRA};
	logic [31:0] corners [3] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000};

	alu uut (
		.clock  (clock),
		.rst_n  (rst_n),
		.start  (start),
		.req    (req),
		.busy   (busy),
		.done   (done),
		.result (result)
	);

	always #4 clock = ~clock;

	// Hard stop if done never shows up
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, done never arrived", cycle_count);
			$display("Finished with errors");
			$finish;
		end
	end

	// Expected result straight from the opcode rules
	function automatic alu_result_t alu_model(input alu_req_t r);
		alu_result_t res;
		logic [32:0] wide;
		logic [63:0] dbl;
		logic [31:0] word;
		logic [4:0]  amt;
		res = '0;
		amt = r.b[4:0];
		case (r.op)
			OP_NOT: res.value = {32'h0, ~r.a};
			OP_AND: res.value = {32'h0, r.a & r.b};
			OP_OR:  res.value = {32'h0, r.a | r.b};
			OP_ADD: begin
				wide = {1'b0, r.a} + {1'b0, r.b};
				res.value = {32'h0, wide[31:0]};
				res.status.carry = wide[32];
				res.status.overflow = (r.a[31] == r.b[31]) && (wide[31] != r.a[31]);
			end
			OP_SUB: begin
				res.value = {32'h0, r.a - r.b};
				// Carry means no borrow
				res.status.carry = r.a >= r.b;
				res.status.overflow = (r.a[31] != r.b[31]) && (res.value[31] != r.a[31]);
			end
			OP_NEG: begin
				res.value = {32'h0, 32'h0 - r.b};
				res.status.carry = r.b == 32'h0;
				// Only the most negative value cannot be negated
				res.status.overflow = r.b == 32'h8000_0000;
			end
			OP_SHL, OP_SHLA: res.value = {32'h0, r.a << amt};
			OP_SHR: res.value = {32'h0, r.a >> amt};
			OP_SHRA: begin
				word = $signed(r.a) >>> amt;
				res.value = {32'h0, word};
			end
			OP_ROL: begin
				dbl = {r.a, r.a} << amt;
				res.value = {32'h0, dbl[63:32]};
			end
			OP_ROR: begin
				dbl = {r.a, r.a} >> amt;
				res.value = {32'h0, dbl[31:0]};
			end
			OP_MUL: res.value = {32'h0, r.a} * {32'h0, r.b};
			OP_DIV: begin
				if (r.b == 32'h0) begin
					res.value = {r.a, 32'hffff_ffff};
					res.status.div_by_zero = 1'b1;
				end else begin
					res.value = {r.a % r.b, r.a / r.b};
				end
			end
			default: res.status.illegal_op = 1'b1;
		endcase
		res.status.zero = res.value == 64'h0;
		return res;
	endfunction

	function automatic alu_req_t make_req(input alu_op_e op, input logic [31:0] a,
		input logic [31:0] b);
		alu_req_t r;
		r.op = op;
		r.a = a;
		r.b = b;
		return r;
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			$display("Mismatch %s: expected %h, got %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic report_test(input string label, input int errs_before);
		if (error_count == errs_before) begin
			pass_count++;
			$display("ok   %s", label);
		end else begin
			fail_count++;
			$display("FAIL %s", label);
		end
	endtask

	// Issue one request and compare once done shows up
	// Entered and left 1 ns after a rising edge
	task automatic run_op(input alu_req_t r, input int exp_latency, input bit poke);
		alu_result_t exp;
		int cycles;
		int errs_before;
		exp = alu_model(r);
		errs_before = error_count;
		start = 1'b1;
		req = r;
		// Capture edge
		@(posedge clock);
		#1;
		start = 1'b0;
		cycles = 0;
		while (done !== 1'b1) begin
			// Stray start in the middle of an iterative op
			if (poke && cycles == 4) begin
				start = 1'b1;
				req = make_req(OP_ADD, ~r.a, r.b);
			end else begin
				start = 1'b0;
			end
			@(posedge clock);
			#1;
			cycles++;
		end
		start = 1'b0;
		check_value("result.value", exp.value, result.value);
		check_value("status.zero", exp.status.zero, result.status.zero);
		check_value("status.carry", exp.status.carry, result.status.carry);
		check_value("status.overflow", exp.status.overflow, result.status.overflow);
		check_value("status.div_by_zero", exp.status.div_by_zero, result.status.div_by_zero);
		check_value("status.illegal_op", exp.status.illegal_op, result.status.illegal_op);
		if (exp_latency > 0)
			check_value("latency", exp_latency, cycles);
		if (poke) begin
			// Ignored start must not spawn a second operation
			@(posedge clock);
			#1;
			check_value("done", 1'b0, done);
			check_value("busy", 1'b0, busy);
		end
		report_test($sformatf("op=%b a=%h b=%h cycles=%0d", r.op, r.a, r.b, cycles),
			errs_before);
	endtask

	initial begin
		logic [31:0] ra;
		logic [31:0] rb;
		int errs_before;
		rst_n = 1'b0;
		start = 1'b0;
		req = '0;
		repeat (3) @(posedge clock);
		#1;
		rst_n = 1'b1;

		// Idle state after reset
		errs_before = error_count;
		check_value("busy", 1'b0, busy);
		check_value("done", 1'b0, done);
		check_value("result.value", 64'h0, result.value);
		check_value("result.status", 64'h0, result.status);
		report_test("reset state", errs_before);

		// Fast op: done at the second edge after start is raised
		ra = $random(seed);
		rb = $random(seed);
		run_op(make_req(OP_AND, ra, rb), 1, 1'b0);

		// Logic and add class on corner pairs and random pairs
		foreach (logic_ops[k]) begin
			for (int i = 0; i < 3; i++) begin
				for (int j = 0; j < 3; j++)
					run_op(make_req(logic_ops[k], corners[i], corners[j]), 1, 1'b0);
			end
			for (int i = 0; i < 4; i++) begin
				ra = $random(seed);
				rb = $random(seed);
				run_op(make_req(logic_ops[k], ra, rb), 1, 1'b0);
			end
		end

		// Every shift amount, upper bits of b are noise
		foreach (shift_ops[k]) begin
			for (int amt = 0; amt < 32; amt++) begin
				ra = $random(seed);
				if (shift_ops[k] == OP_SHRA && amt % 2 == 0)
					ra = ra | 32'h8000_0000;
				rb = $random(seed);
				rb = (rb & ~32'h1f) | amt;
				run_op(make_req(shift_ops[k], ra, rb), 1, 1'b0);
			end
		end

		// Multiply extremes then random operands
		run_op(make_req(OP_MUL, 32'hffff_ffff, 32'hffff_ffff), ITER_LATENCY, 1'b0);
		run_op(make_req(OP_MUL, 32'h0000_0000, 32'hffff_ffff), ITER_LATENCY, 1'b0);
		run_op(make_req(OP_MUL, 32'h8000_0000, 32'h0000_0002), ITER_LATENCY, 1'b0);
		run_op(make_req(OP_MUL, 32'h0000_0001, 32'hffff_ffff), ITER_LATENCY, 1'b0);
		for (int i = 0; i < 6; i++) begin
			ra = $random(seed);
			rb = $random(seed);
			run_op(make_req(OP_MUL, ra, rb), ITER_LATENCY, 1'b0);
		end

		// Divisors of varied size, then zero divisors
		for (int i = 0; i < 8; i++) begin
			ra = $random(seed);
			rb = $random(seed);
			rb = rb >> (i * 3);
			run_op(make_req(OP_DIV, ra, rb), ITER_LATENCY, 1'b0);
		end
		ra = $random(seed);
		run_op(make_req(OP_DIV, ra, 32'h0), ITER_LATENCY, 1'b0);
		run_op(make_req(OP_DIV, 32'h0, 32'h0), ITER_LATENCY, 1'b0);

		// Unassigned opcodes
		ra = $random(seed);
		rb = $random(seed);
		run_op(make_req(alu_op_e'(5'b00000), ra, rb), 1, 1'b0);
		run_op(make_req(alu_op_e'(5'b10110), ra, rb), 1, 1'b0);
		run_op(make_req(alu_op_e'(5'b01010), ra, rb), 1, 1'b0);
		run_op(make_req(alu_op_e'(5'b11111), ra, rb), 1, 1'b0);

		// Start while busy during a multiply
		ra = $random(seed);
		rb = $random(seed);
		run_op(make_req(OP_MUL, ra, rb), ITER_LATENCY, 1'b1);

		$display("%0d tests passed, %0d tests failed, %0d errors",
			pass_count, fail_count, error_count);
		if (error_count == 0 && fail_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- source/alu.sv
`timescale 1ns/1ps

module alu (
	input  logic                      clock,
	input  logic                      rst_n,
	input  logic                      start,
	input  alu_data_pkg::alu_req_t    req,
	output logic                      busy,
	output logic                      done,
	output alu_data_pkg::alu_result_t result
);
	import alu_isa_pkg::*;
	import alu_data_pkg::*;

	typedef enum logic [1:0] {
		idle,
		exec,
		wait_unit
	} state_e;

	state_e              state;
	// Captured request for the whole operation
	alu_req_t            req_q;

	logic [DATA_W-1:0]   logic_value;
	logic                logic_carry;
	logic                logic_overflow;
	logic [DATA_W-1:0]   shift_value;

	logic                mul_go;
	logic                mul_ready;
	logic [RESULT_W-1:0] product;

	logic                div_go;
	logic                div_ready;
	logic [DATA_W-1:0]   quotient;
	logic [DATA_W-1:0]   remainder;
	logic                div_by_zero;

	logic                unit_ready;
	alu_result_t         res_next;

	// Single-cycle units work straight off the captured request
	alu_logic_unit u_logic (
		.op       (req_q.op),
		.a        (req_q.a),
		.b        (req_q.b),
		.value    (logic_value),
		.carry    (logic_carry),
		.overflow (logic_overflow)
	);

	shifter u_shifter (
		.op    (req_q.op),
		.a     (req_q.a),
		.shamt (req_q.b[SHAMT_W-1:0]),
		.value (shift_value)
	);

	// Iterative units get one go cycle right after capture
	assign mul_go = state == exec && req_q.op == OP_MUL;
	assign div_go = state == exec && req_q.op == OP_DIV;

	multiplier u_mul (
		.clock   (clock),
		.rst_n   (rst_n),
		.go      (mul_go),
		.a       (req_q.a),
		.b       (req_q.b),
		.product (product),
		.ready   (mul_ready)
	);

	divider u_div (
		.clock       (clock),
		.rst_n       (rst_n),
		.go          (div_go),
		.a           (req_q.a),
		.b           (req_q.b),
		.quotient    (quotient),
		.remainder   (remainder),
		.div_by_zero (div_by_zero),
		.ready       (div_ready)
	);

	// Only the launched unit's ready counts
	assign unit_ready = req_q.op == OP_MUL ? mul_ready : div_ready;

	assign busy = state != idle;

	// Result assembly by opcode class
	always_comb begin
		res_next = '0;
		if (is_logic_op(req_q.op) || is_add_op(req_q.op)) begin
			res_next.value           = RESULT_W'(logic_value);
			res_next.status.carry    = logic_carry;
			res_next.status.overflow = logic_overflow;
		end else if (is_shift_op(req_q.op)) begin
			res_next.value = RESULT_W'(shift_value);
		end else if (req_q.op == OP_MUL) begin
			res_next.value = product;
		end else if (req_q.op == OP_DIV) begin
			// Remainder high and quotient low
			res_next.value              = {remainder, quotient};
			res_next.status.div_by_zero = div_by_zero;
		end else begin
			res_next.status.illegal_op = 1'b1;
		end
		res_next.status.zero = res_next.value == '0;
	end

	always_ff @(posedge clock) begin
		if (state == idle && start)
			req_q <= req;
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state  <= idle;
			done   <= 1'b0;
			result <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				idle: begin
					if (start)
						state <= exec;
				end
				exec: begin
					if (is_iter_op(req_q.op)) begin
						state <= wait_unit;
					end else begin
						// Fast and illegal ops finish here
						result <= res_next;
						done   <= 1'b1;
						state  <= idle;
					end
				end
				wait_unit: begin
					if (unit_ready) begin
						result <= res_next;
						done   <= 1'b1;
						state  <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	done_after_busy: assert property (
		@(posedge clock) disable iff (!rst_n)
		done |-> $past(busy)
	) else $error("done without a preceding busy cycle");

	// Overlapping starts are dropped
	no_start_while_busy: assert property (
		@(posedge clock) disable iff (!rst_n)
		busy |-> !start
	) else $warning("start while busy is ignored");

endmodule

//--- source/divider.sv
`timescale 1ns/1ps

module divider (
	input  logic                            clock,
	input  logic                            rst_n,
	input  logic                            go,
	input  logic [alu_data_pkg::DATA_W-1:0] a,
	input  logic [alu_data_pkg::DATA_W-1:0] b,
	output logic [alu_data_pkg::DATA_W-1:0] quotient,
	output logic [alu_data_pkg::DATA_W-1:0] remainder,
	output logic                            div_by_zero,
	output logic                            ready
);
	import alu_data_pkg::*;

	logic [SHAMT_W:0]  count;
	logic              running;
	// Dividend bits shift out the top while quotient bits enter below
	logic [DATA_W-1:0] dq;
	logic [DATA_W-1:0] rem;
	logic [DATA_W-1:0] divisor;
	logic              zero_div;
	// Partial remainder with the next dividend bit appended
	logic [DATA_W:0]   shifted;
	logic [DATA_W+1:0] diff;
	logic              fits;

	assign running = count != '0;

	assign shifted = {rem, dq[DATA_W-1]};
	// Trial subtract, borrow shows up in the top bit
	assign diff = {1'b0, shifted} - {2'b00, divisor};
	assign fits = ~diff[DATA_W+1];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			count <= '0;
			ready <= 1'b0;
		end else begin
			ready <= running && count == 1;
			if (go)
				count <= (SHAMT_W+1)'(DATA_W);
			else if (running)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (go) begin
			dq       <= a;
			rem      <= '0;
			divisor  <= b;
			zero_div <= b == '0;
		end else if (running) begin
			// Restore by keeping the shifted value when the divisor does not fit
			rem <= fits ? diff[DATA_W-1:0] : shifted[DATA_W-1:0];
			dq  <= {dq[DATA_W-2:0], fits};
		end
	end

	// Zero divisor always fits
	// so the quotient ends all ones and the remainder ends as a
	assign quotient    = dq;
	assign remainder   = rem;
	assign div_by_zero = zero_div;

	ready_one_cycle: assert property (
		@(posedge clock) disable iff (!rst_n)
		ready |=> !ready
	) else $error("divider ready held longer than one cycle");

	count_in_range: assert property (
		@(posedge clock) disable iff (!rst_n)
		count <= DATA_W
	) else $error("divider iteration count out of range");

endmodule

//--- source/multiplier.sv
`timescale 1ns/1ps

module multiplier (
	input  logic                              clock,
	input  logic                              rst_n,
	input  logic                              go,
	input  logic [alu_data_pkg::DATA_W-1:0]   a,
	input  logic [alu_data_pkg::DATA_W-1:0]   b,
	output logic [alu_data_pkg::RESULT_W-1:0] product,
	output logic                              ready
);
	import alu_data_pkg::*;

	// Iterations left, zero when idle
	logic [SHAMT_W:0]    count;
	logic                running;
	// Upper half collects partial sums, lower half takes shifted-out bits
	logic [RESULT_W-1:0] acc;
	logic [DATA_W-1:0]   mcand;
	// Multiplier bits consumed LSB first
	logic [DATA_W-1:0]   mplier;
	logic [DATA_W:0]     partial;

	assign running = count != '0;

	// Add the multiplicand when the current multiplier bit is set
	assign partial = {1'b0, acc[RESULT_W-1:DATA_W]} +
		(mplier[0] ? {1'b0, mcand} : {(DATA_W+1){1'b0}});

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			count <= '0;
			ready <= 1'b0;
		end else begin
			// Pulse on the last iteration
			ready <= running && count == 1;
			if (go)
				count <= (SHAMT_W+1)'(DATA_W);
			else if (running)
				count <= count - 1'b1;
		end
	end

	// Datapath
	always_ff @(posedge clock) begin
		if (go) begin
			acc    <= '0;
			mcand  <= a;
			mplier <= b;
		end else if (running) begin
			// Shift right one place with the carry of the add
			acc    <= {partial, acc[DATA_W-1:1]};
			mplier <= mplier >> 1;
		end
	end

	assign product = acc;

	// Top must wait for ready before launching again
	go_while_running: assert property (
		@(posedge clock) disable iff (!rst_n)
		go |-> !running
	) else $error("multiplier launched while running");

endmodule

//--- source/shifter.sv
`timescale 1ns/1ps

module shifter (
	input  alu_isa_pkg::alu_op_e             op,
	input  logic [alu_data_pkg::DATA_W-1:0]  a,
	input  logic [alu_data_pkg::SHAMT_W-1:0] shamt,
	output logic [alu_data_pkg::DATA_W-1:0]  value
);
	import alu_isa_pkg::*;
	import alu_data_pkg::*;

	logic [4:0]        op_bits;
	logic              right;
	logic              rotate;
	logic              fill;
	logic [DATA_W-1:0] a_rev;
	logic [DATA_W-1:0] shifted;
	logic [DATA_W-1:0] shifted_rev;
	logic [DATA_W-1:0] stage [SHAMT_W+1];

	assign op_bits = op;
	assign right   = op_bits[OP_RIGHT_BIT];
	assign rotate  = op_bits[OP_ROT_BIT];

	// Sign fill only on arithmetic right shifts
	// SHLA falls through as a plain left shift
	assign fill = op_bits[OP_ARITH_BIT] & right & ~rotate & a[DATA_W-1];

	// Left operations reuse the right network on bit-reversed data
	assign a_rev = {<<{a}};

	always_comb begin
		int src;
		stage[0] = right ? a : a_rev;
		// Stage i moves by 2**i when its shamt bit is set
		for (int i = 0; i < SHAMT_W; i++) begin
			for (int j = 0; j < DATA_W; j++) begin
				src = j + (1 << i);
				if (!shamt[i])
					stage[i+1][j] = stage[i][j];
				else if (src < DATA_W || rotate)
					// Rotate wraps the low bits around to the top
					stage[i+1][j] = stage[i][src % DATA_W];
				else
					stage[i+1][j] = fill;
			end
		end
	end

	assign shifted     = stage[SHAMT_W];
	assign shifted_rev = {<<{shifted}};

	// Undo the reversal for left operations
	assign value = right ? shifted : shifted_rev;

endmodule

//--- source/alu_logic_unit.sv
`timescale 1ns/1ps

module alu_logic_unit (
	input  alu_isa_pkg::alu_op_e            op,
	input  logic [alu_data_pkg::DATA_W-1:0] a,
	input  logic [alu_data_pkg::DATA_W-1:0] b,
	output logic [alu_data_pkg::DATA_W-1:0] value,
	output logic                            carry,
	output logic                            overflow
);
	import alu_isa_pkg::*;
	import alu_data_pkg::*;

	logic [4:0]        op_bits;
	logic              add_class;
	logic              sub;
	logic [DATA_W-1:0] add_a;
	logic [DATA_W-1:0] add_b;
	logic [DATA_W:0]   sum;

	assign op_bits   = op;
	assign add_class = is_add_op(op);

	// Negate muxes in zero for a, so NEG gives 0 - b
	assign add_a = op_bits[OP_NEG_BIT] ? '0 : a;
	// Subtract is invert plus carry in
	assign sub   = op_bits[OP_SUB_BIT];
	assign add_b = sub ? ~b : b;
	assign sum   = {1'b0, add_a} + {1'b0, add_b} + {{DATA_W{1'b0}}, sub};

	// Carry out of the top bit
	assign carry = add_class & sum[DATA_W];
	// Signed overflow when like-signed inputs give an unlike-signed sum
	assign overflow = add_class & (add_a[DATA_W-1] == add_b[DATA_W-1]) &
		(sum[DATA_W-1] != add_a[DATA_W-1]);

	always_comb begin
		case (op)
			OP_NOT:  value = ~a;
			OP_AND:  value = a & b;
			OP_OR:   value = a | b;
			OP_ADD, OP_SUB, OP_NEG: begin
				value = sum[DATA_W-1:0];
			end
			// Shifts and iterative ops are handled elsewhere
			default: value = '0;
		endcase
	end

endmodule

//--- source/alu_data_pkg.sv
package alu_data_pkg;

	// Operand and result widths
	localparam int DATA_W   = 32;
	localparam int RESULT_W = 64;
	// Shift amount comes from the low bits of b
	localparam int SHAMT_W  = 5;

	// One operation as handed to the ALU
	typedef struct packed {
		alu_isa_pkg::alu_op_e op;
		logic [DATA_W-1:0]    a;
		logic [DATA_W-1:0]    b;
	} alu_req_t;

	// Flags reported alongside the value
	typedef struct packed {
		logic zero;
		logic carry;
		logic overflow;
		logic div_by_zero;
		logic illegal_op;
	} alu_status_t;

	// Registered ALU output
	typedef struct packed {
		logic [RESULT_W-1:0] value;
		alu_status_t         status;
	} alu_result_t;

endpackage

//--- source/alu_isa_pkg.sv
package alu_isa_pkg;

	// Shift codes are 1 1 arith rot right
	typedef enum logic [4:0] {
		OP_NOT  = 5'b00001,
		OP_AND  = 5'b00010,
		OP_OR   = 5'b00011,
		OP_ADD  = 5'b00100,
		OP_SUB  = 5'b00101,
		OP_NEG  = 5'b00111,
		OP_MUL  = 5'b01000,
		OP_DIV  = 5'b01001,
		OP_SHL  = 5'b11000,
		OP_SHR  = 5'b11001,
		OP_ROL  = 5'b11010,
		OP_ROR  = 5'b11011,
		OP_SHLA = 5'b11100,
		OP_SHRA = 5'b11101
	} alu_op_e;

	// Add class flags
	localparam int OP_SUB_BIT = 0;
	localparam int OP_NEG_BIT = 1;
	// Shift class flags
	localparam int OP_RIGHT_BIT = 0;
	localparam int OP_ROT_BIT   = 1;
	localparam int OP_ARITH_BIT = 2;

	function automatic logic is_logic_op(alu_op_e op);
		return op inside {OP_NOT, OP_AND, OP_OR};
	endfunction

	function automatic logic is_add_op(alu_op_e op);
		return op inside {OP_ADD, OP_SUB, OP_NEG};
	endfunction

	function automatic logic is_shift_op(alu_op_e op);
		return op inside {OP_SHL, OP_SHR, OP_ROL, OP_ROR, OP_SHLA, OP_SHRA};
	endfunction

	// Multi-cycle units
	function automatic logic is_iter_op(alu_op_e op);
		return op inside {OP_MUL, OP_DIV};
	endfunction

	function automatic logic is_legal_op(alu_op_e op);
		return is_logic_op(op) || is_add_op(op) || is_shift_op(op) || is_iter_op(op);
	endfunction

endpackage
